/* Makefile */
# Verilator flow for the stream demux testbench

TOP := stream_demux_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

# pass only if the run prints the pass message
sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

/* logic/beat_buffer.sv */
/*
 * beat buffer
 * one-beat output register shared by both output streams
 */
module beat_buffer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            accept,
    input  logic                            to_stream2,
    input  logic [demux_pkg::STREAM_W-1:0]  in_data,
    input  logic                            s1_ready,
    input  logic                            s2_ready,
    output logic                            s1_valid,
    output logic                            s2_valid,
    output logic [demux_pkg::STREAM_W-1:0]  s1_data,
    output logic [demux_pkg::STREAM_W-1:0]  s2_data,
    output logic                            buf_free
);
    import demux_pkg::*;

    logic [STREAM_W-1:0] beat_q;
    logic                held;
    logic                leaving;

    assign held = s1_valid || s2_valid;
    assign leaving = (s1_valid && s1_ready) || (s2_valid && s2_ready);

    // empty, or the held beat goes out on this edge
    assign buf_free = !held || leaving;

    //////////////////////////////////////////////////
    // payload
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            beat_q <= in_data;
        end
    end

    // both outputs see the same register, valid picks the owner
    assign s1_data = beat_q;
    assign s2_data = beat_q;

    //////////////////////////////////////////////////
    // output valids
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (accept) begin
            // new beat replaces the one leaving now
            s1_valid <= !to_stream2;
            s2_valid <= to_stream2;
        end else if (leaving) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
    end

    // blocked beat is never overwritten by a new one
    assert property (@(posedge clk) disable iff (rst) (held && !leaving) |-> !accept);

endmodule

/* logic/demux_pkg.sv */
/*
 * stream demux package
 * widths, beat counts, state and register encodings, status and counter structs
 */
package demux_pkg;

    //////////////////////////////////////////////////
    // stream geometry
    //////////////////////////////////////////////////

    // one input beat
    localparam int STREAM_W = 128;
    // 2-bit nucleotide encoding
    localparam int BASE_W = 2;
    // bases packed in one beat
    localparam int BASES_PER_TX = STREAM_W / BASE_W;
    // shift from base count to beat count
    localparam int LOG_BASES_PER_TX = $clog2(BASES_PER_TX);

    // header length fields, in bases
    localparam int S1_LEN_W = 7;
    localparam int S2_LEN_W = 9;
    // wider of the two, also sizes the beats-left counter
    localparam int LEN_W = (S1_LEN_W > S2_LEN_W) ? S1_LEN_W : S2_LEN_W;

    //////////////////////////////////////////////////
    // register port
    //////////////////////////////////////////////////

    localparam int CNT_W = 32;
    localparam int REG_W = 32;
    localparam int ADDR_W = 32;

    // 0x0101 would read as version 1.1
    localparam logic [REG_W-1:0] VERSION = 32'h0001;

    typedef enum logic [ADDR_W-1:0] {
        REG_VERSION  = 32'h00,
        REG_IN_COUNT = 32'h10,
        REG_S1_COUNT = 32'h20,
        REG_STATUS   = 32'h30,
        REG_S2_COUNT = 32'h40
    } reg_addr_e;

    // 3 bits to fit the status word field
    typedef enum logic [2:0] {
        INFO_1 = 3'd0,
        DATA_1 = 3'd1,
        INFO_2 = 3'd2,
        DATA_2 = 3'd3
    } demux_state_e;

    //////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [CNT_W-1:0] in_count;
        logic [CNT_W-1:0] s1_count;
        logic [CNT_W-1:0] s2_count;
    } xfer_counts_t;

    // 32-bit status word, msb first
    typedef struct packed {
        logic [1:0]   spare_hi;
        logic         load_info;
        logic         to_stream2;
        logic         spare_mid;
        demux_state_e state;
        logic [1:0]   spare_lo;
        logic         in_valid;
        logic         in_ready;
        logic         s1_valid;
        logic         s1_ready;
        logic         s2_valid;
        logic         s2_ready;
        logic [15:0]  beats_left;
    } status_word_t;

endpackage

/* logic/segment_sequencer.sv */
/*
 * segment sequencer
 * reads each header length, counts beats left and gates input acceptance
 */
module segment_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  logic [demux_pkg::LEN_W-1:0]     in_len_field,
    input  logic                            buf_free,
    output logic                            in_ready,
    output logic                            accept,
    output logic                            to_stream2,
    output demux_pkg::status_word_t         status
);
    import demux_pkg::*;

    demux_state_e       state;
    demux_state_e       next_state;
    logic               load_info;
    logic               in_data_state;
    logic [LEN_W-1:0]   beats_left;
    logic [LEN_W-1:0]   len_mask;
    logic [LEN_W-1:0]   len_masked;
    logic [LEN_W:0]     len_round;
    logic [LEN_W-1:0]   seg_beats;

    //////////////////////////////////////////////////
    // header decode
    //////////////////////////////////////////////////

    // each stream has its own length field width
    assign len_mask = to_stream2 ? LEN_W'((1 << S2_LEN_W) - 1) : LEN_W'((1 << S1_LEN_W) - 1);
    assign len_masked = in_len_field & len_mask;

    // round up to whole beats, one extra bit so the add cannot wrap
    assign len_round = {1'b0, len_masked} + (LEN_W + 1)'(BASES_PER_TX - 1);
    // header beat plus data beats
    assign seg_beats = LEN_W'(len_round >> LOG_BASES_PER_TX) + 1'b1;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    assign load_info = (state == INFO_1) || (state == INFO_2);
    assign in_data_state = (state == DATA_1) || (state == DATA_2);
    assign to_stream2 = (state == INFO_2) || (state == DATA_2);

    // header is only peeked in INFO, it gets taken in DATA
    assign in_ready = in_data_state && buf_free;
    assign accept = in_valid && in_ready;

    always_comb begin
        next_state = state;
        case (state)
            INFO_1: if (in_valid) next_state = DATA_1;
            DATA_1: if (accept && beats_left == LEN_W'(1)) next_state = INFO_2;
            INFO_2: if (in_valid) next_state = DATA_2;
            DATA_2: if (accept && beats_left == LEN_W'(1)) next_state = INFO_1;
            default: next_state = INFO_1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= INFO_1;
            beats_left <= '0;
        end else begin
            state <= next_state;
            // load once a header shows up, count down per accepted beat
            if (load_info && in_valid) begin
                beats_left <= seg_beats;
            end else if (accept) begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    // handshake bits are merged in by the register block
    always_comb begin
        status = '0;
        status.load_info = load_info;
        status.to_stream2 = to_stream2;
        status.state = state;
        status.beats_left = 16'(beats_left);
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // peeked header stays on the input until DATA takes it
    assert property (@(posedge clk) disable iff (rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_len_field)));

    // every segment is entered with at least its header beat pending
    assert property (@(posedge clk) disable iff (rst) in_data_state |-> beats_left != '0);

endmodule

/* logic/status_regs.sv */
/*
 * status registers
 * builds the status word and answers read-only register accesses
 */
module status_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            reg_rd,
    input  logic [demux_pkg::ADDR_W-1:0]    reg_addr,
    input  demux_pkg::xfer_counts_t         counts,
    input  demux_pkg::status_word_t         seq_status,
    input  logic                            in_valid,
    input  logic                            in_ready,
    input  logic                            s1_valid,
    input  logic                            s1_ready,
    input  logic                            s2_valid,
    input  logic                            s2_ready,
    output logic [demux_pkg::REG_W-1:0]     reg_rdata
);
    import demux_pkg::*;

    status_word_t status_next;
    status_word_t status_q;

    //////////////////////////////////////////////////
    // status word
    //////////////////////////////////////////////////

    // sequencer fields plus the live handshakes
    always_comb begin
        status_next = seq_status;
        status_next.in_valid = in_valid;
        status_next.in_ready = in_ready;
        status_next.s1_valid = s1_valid;
        status_next.s1_ready = s1_ready;
        status_next.s2_valid = s2_valid;
        status_next.s2_ready = s2_ready;
    end

    // snapshot every cycle, so a read sees the previous cycle
    always_ff @(posedge clk) begin
        status_q <= status_next;
    end

    //////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////

    // data one cycle after the strobe, zero when idle
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            case (reg_addr)
                REG_VERSION:  reg_rdata <= VERSION;
                REG_IN_COUNT: reg_rdata <= counts.in_count;
                REG_S1_COUNT: reg_rdata <= counts.s1_count;
                REG_STATUS:   reg_rdata <= status_q;
                REG_S2_COUNT: reg_rdata <= counts.s2_count;
                // unmapped offsets read as zero
                default:      reg_rdata <= '0;
            endcase
        end else begin
            reg_rdata <= '0;
        end
    end

endmodule

/* logic/stream_demux.sv */
/*
 * stream demux top
 * splits alternating header-led segments onto two output streams
 */
module stream_demux (
    input  logic                            clk,
    input  logic                            rst,

    // input stream
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [demux_pkg::STREAM_W-1:0]  in_data,

    // output stream 1
    output logic                            s1_valid,
    input  logic                            s1_ready,
    output logic [demux_pkg::STREAM_W-1:0]  s1_data,

    // output stream 2
    output logic                            s2_valid,
    input  logic                            s2_ready,
    output logic [demux_pkg::STREAM_W-1:0]  s2_data,

    // read-only register port
    input  logic                            reg_rd,
    input  logic [demux_pkg::ADDR_W-1:0]    reg_addr,
    output logic [demux_pkg::REG_W-1:0]     reg_rdata
);
    import demux_pkg::*;

    logic         accept;
    logic         to_stream2;
    logic         buf_free;
    status_word_t seq_status;
    xfer_counts_t counts;

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    // length sits in the low bits of the header beat
    segment_sequencer u_sequencer (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_len_field(in_data[LEN_W-1:0]), .buf_free(buf_free),
        .in_ready(in_ready), .accept(accept), .to_stream2(to_stream2),
        .status(seq_status)
    );

    beat_buffer u_buffer (
        .clk(clk), .rst(rst),
        .accept(accept), .to_stream2(to_stream2), .in_data(in_data),
        .s1_ready(s1_ready), .s2_ready(s2_ready),
        .s1_valid(s1_valid), .s2_valid(s2_valid),
        .s1_data(s1_data), .s2_data(s2_data),
        .buf_free(buf_free)
    );

    //////////////////////////////////////////////////
    // debug and register access
    //////////////////////////////////////////////////

    transfer_counters u_counters (
        .clk(clk), .rst(rst), .accept(accept),
        .s1_valid(s1_valid), .s1_ready(s1_ready),
        .s2_valid(s2_valid), .s2_ready(s2_ready),
        .counts(counts)
    );

    status_regs u_regs (
        .clk(clk), .rst(rst),
        .reg_rd(reg_rd), .reg_addr(reg_addr),
        .counts(counts), .seq_status(seq_status),
        .in_valid(in_valid), .in_ready(in_ready),
        .s1_valid(s1_valid), .s1_ready(s1_ready),
        .s2_valid(s2_valid), .s2_ready(s2_ready),
        .reg_rdata(reg_rdata)
    );

endmodule

/* logic/transfer_counters.sv */
/*
 * transfer counters
 * beats accepted on the input and delivered on each output
 */
module transfer_counters (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        accept,
    input  logic                        s1_valid,
    input  logic                        s1_ready,
    input  logic                        s2_valid,
    input  logic                        s2_ready,
    output demux_pkg::xfer_counts_t     counts
);

    logic s1_xfer;
    logic s2_xfer;

    assign s1_xfer = s1_valid && s1_ready;
    assign s2_xfer = s2_valid && s2_ready;

    // free running, wrap at 2^32
    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else begin
            if (accept) begin
                counts.in_count <= counts.in_count + 1'b1;
            end
            if (s1_xfer) begin
                counts.s1_count <= counts.s1_count + 1'b1;
            end
            if (s2_xfer) begin
                counts.s2_count <= counts.s2_count + 1'b1;
            end
        end
    end

    // nothing is dropped or duplicated, the buffer holds at most one beat
    // difference taken mod 2^32 so wrap is harmless
    assert property (@(posedge clk) disable iff (rst)
        (counts.in_count - counts.s1_count - counts.s2_count) <= 32'd1);

endmodule

/* verification/stream_demux_tb.sv */
/*
 * stream demux testbench
 * alternating segment traffic, queue-based routing model, register readback
 */
module stream_demux_tb;
    import demux_pkg::*;

    logic                clk = 1'b0;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    logic [STREAM_W-1:0] in_data;
    logic                s1_valid;
    logic                s1_ready;
    logic [STREAM_W-1:0] s1_data;
    logic                s2_valid;
    logic                s2_ready;
    logic [STREAM_W-1:0] s2_data;
    logic                reg_rd;
    logic [ADDR_W-1:0]   reg_addr;
    logic [REG_W-1:0]    reg_rdata;

    // generated beats, directed first, then random
    logic [STREAM_W-1:0] dir_q[$];
    logic [STREAM_W-1:0] rnd_q[$];
    logic [STREAM_W-1:0] stim_q[$];
    // expected beats per output
    logic [STREAM_W-1:0] q1[$];
    logic [STREAM_W-1:0] q2[$];
    logic [STREAM_W-1:0] exp1_head;
    logic [STREAM_W-1:0] exp2_head;
    int                  exp1_n;
    int                  exp2_n;
    // model state, beats left in segment and which stream owns it
    int                  m_left;
    bit                  m_s2;
    int                  n_in;
    int                  n_s1;
    int                  n_s2;
    bit                  took;
    bit                  bp_on;
    int                  hold_left;
    bit                  check_drain;
    logic [REG_W-1:0]    rd_exp;
    logic [REG_W-1:0]    rd_mask;
    int                  errors;
    int                  errors_seen;
    int                  tests_run;
    int                  tests_failed;
    int                  cycles;
    int                  cycle_limit = 100000;

    stream_demux DUT (.*);

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [STREAM_W-1:0] rand_beat();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    // header with length in the low bits, random bits above, then data beats
    task automatic add_segment(input bit rnd, input bit s2, input int unsigned len);
        logic [STREAM_W-1:0] beat;
        int unsigned         n_data;
        beat = rand_beat();
        if (s2) beat[S2_LEN_W-1:0] = len[S2_LEN_W-1:0];
        else beat[S1_LEN_W-1:0] = len[S1_LEN_W-1:0];
        n_data = (len + BASES_PER_TX - 1) / BASES_PER_TX;
        if (rnd) rnd_q.push_back(beat);
        else dir_q.push_back(beat);
        for (int unsigned i = 0; i < n_data; i++) begin
            if (rnd) rnd_q.push_back(rand_beat());
            else dir_q.push_back(rand_beat());
        end
    endtask

    task automatic flag_mismatch(input string name, input logic [STREAM_W-1:0] exp,
                                 input logic [STREAM_W-1:0] got);
        $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got);
        errors++;
    endtask

    task automatic flag_failure(input string what);
        $display("Error: %s", what);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > errors_seen) begin
            tests_failed++;
            $display("test %0d %s: FAIL (%0d errors)", tests_run, name, errors - errors_seen);
        end else begin
            $display("test %0d %s: PASS", tests_run, name);
        end
        errors_seen = errors;
    endtask

    // present each beat until it is taken, optional idle gaps between beats
    task automatic drive_stream(input int gap_pct);
        int next_idx;
        next_idx = 0;
        while (next_idx < stim_q.size() || in_valid) begin
            @(negedge clk);
            if (in_valid && took) in_valid = 1'b0;
            if (!in_valid && next_idx < stim_q.size() && $urandom_range(0, 99) >= gap_pct) begin
                in_data = stim_q[next_idx];
                in_valid = 1'b1;
                next_idx++;
            end
        end
    endtask

    // wait for the DUT to go quiet, then the model queues must be empty too
    task automatic drain_outputs();
        int idle;
        idle = 0;
        while (idle < 4) begin
            @(negedge clk);
            if (!s1_valid && !s2_valid && !in_valid) idle++;
            else idle = 0;
        end
        check_drain = 1'b1;
        @(negedge clk);
        check_drain = 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic [REG_W-1:0] mask,
                            input logic [REG_W-1:0] exp);
        @(negedge clk);
        reg_rd = 1'b1;
        reg_addr = addr;
        rd_mask = mask;
        rd_exp = exp;
        @(negedge clk);
        reg_rd = 1'b0;
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // reference model and ready generator
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            q1.delete();
            q2.delete();
            m_left = 0;
            m_s2 = 1'b0;
            took = 1'b0;
            n_in = 0;
            n_s1 = 0;
            n_s2 = 0;
        end else begin
            took = in_valid && in_ready;
            if (s1_valid && s1_ready) begin
                if (q1.size() > 0) void'(q1.pop_front());
                n_s1++;
            end
            if (s2_valid && s2_ready) begin
                if (q2.size() > 0) void'(q2.pop_front());
                n_s2++;
            end
            if (took) begin
                // header opens a segment of 1 + ceil(len / 64) beats
                if (m_left == 0) begin
                    m_left = m_s2 ? int'(in_data[S2_LEN_W-1:0]) : int'(in_data[S1_LEN_W-1:0]);
                    m_left = 1 + (m_left + BASES_PER_TX - 1) / BASES_PER_TX;
                end
                if (m_s2) q2.push_back(in_data);
                else q1.push_back(in_data);
                n_in++;
                m_left--;
                if (m_left == 0) m_s2 = !m_s2;
            end
        end
        exp1_n <= q1.size();
        exp2_n <= q2.size();
        exp1_head <= (q1.size() > 0) ? q1[0] : '0;
        exp2_head <= (q2.size() > 0) ? q2[0] : '0;
    end

    // random readies with occasional stretches held high
    always @(negedge clk) begin
        if (!bp_on) begin
            s1_ready = 1'b1;
            s2_ready = 1'b1;
        end else if (hold_left > 0) begin
            hold_left--;
            s1_ready = 1'b1;
            s2_ready = 1'b1;
        end else begin
            if ($urandom_range(0, 9) == 0) hold_left = $urandom_range(4, 16);
            s1_ready = 1'($urandom_range(0, 1));
            s2_ready = 1'($urandom_range(0, 1));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) (s1_valid && s1_ready) |-> exp1_n != 0)
        else flag_failure("stream 1 delivered a beat that was not expected");
    assert property (@(posedge clk) disable iff (rst) (s2_valid && s2_ready) |-> exp2_n != 0)
        else flag_failure("stream 2 delivered a beat that was not expected");
    assert property (@(posedge clk) disable iff (rst)
        (s1_valid && s1_ready && exp1_n != 0) |-> s1_data == exp1_head)
        else flag_mismatch("s1_data", $sampled(exp1_head), $sampled(s1_data));
    assert property (@(posedge clk) disable iff (rst)
        (s2_valid && s2_ready && exp2_n != 0) |-> s2_data == exp2_head)
        else flag_mismatch("s2_data", $sampled(exp2_head), $sampled(s2_data));

    // blocked beat holds, and nothing new comes in behind it
    assert property (@(posedge clk) disable iff (rst)
        (s1_valid && !s1_ready) |=> (s1_valid && $stable(s1_data)))
        else flag_failure("stream 1 beat changed or dropped while blocked");
    assert property (@(posedge clk) disable iff (rst)
        (s2_valid && !s2_ready) |=> (s2_valid && $stable(s2_data)))
        else flag_failure("stream 2 beat changed or dropped while blocked");
    assert property (@(posedge clk) disable iff (rst)
        ((s1_valid && !s1_ready) || (s2_valid && !s2_ready)) |-> !in_ready)
        else flag_failure("in_ready high while the held beat is blocked");

    assert property (@(posedge clk) disable iff (rst) !(s1_valid && s2_valid))
        else flag_failure("both output valids high together");
    assert property (@(posedge clk) $fell(rst) |->
        (!in_ready && !s1_valid && !s2_valid && reg_rdata == '0))
        else flag_failure("outputs not cleared right after reset");

    assert property (@(posedge clk) check_drain |-> (exp1_n == 0 && exp2_n == 0))
        else flag_failure("expected beats never came out after traffic stopped");

    // read data one cycle after the strobe, zero otherwise
    assert property (@(posedge clk) disable iff (rst) reg_rd |=> (reg_rdata & rd_mask) == rd_exp)
        else flag_mismatch("reg_rdata", 128'($sampled(rd_exp)),
                           128'($sampled(reg_rdata) & $sampled(rd_mask)));
    assert property (@(posedge clk) disable iff (rst) !reg_rd |=> reg_rdata == '0)
        else flag_failure("reg_rdata nonzero without a read");

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(83493));
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        s1_ready = 1'b0;
        s2_ready = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        rd_exp = '0;
        rd_mask = '0;
        bp_on = 1'b0;
        hold_left = 0;
        check_drain = 1'b0;

        // max length, one base, empty and exactly one full beat
        add_segment(1'b0, 1'b0, (1 << S1_LEN_W) - 1);
        add_segment(1'b0, 1'b1, (1 << S2_LEN_W) - 1);
        add_segment(1'b0, 1'b0, 1);
        add_segment(1'b0, 1'b1, 1);
        add_segment(1'b0, 1'b0, 0);
        add_segment(1'b0, 1'b1, 0);
        add_segment(1'b0, 1'b0, 64);
        add_segment(1'b0, 1'b1, 64);
        for (int i = 0; i < 40; i++) begin
            add_segment(1'b1, 1'b0, $urandom_range(0, (1 << S1_LEN_W) - 1));
            add_segment(1'b1, 1'b1, $urandom_range(0, (1 << S2_LEN_W) - 1));
        end
        cycle_limit = 4 * (dir_q.size() + rnd_q.size()) + 200;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        finish_test("reset");

        stim_q = dir_q;
        drive_stream(0);
        drain_outputs();
        finish_test("segment boundaries");

        bp_on = 1'b1;
        stim_q = rnd_q;
        drive_stream(20);
        bp_on = 1'b0;
        drain_outputs();
        finish_test("random traffic with back-pressure");

        // status: state INFO_1 and both output valids low
        read_reg(REG_VERSION, '1, 32'h0001);
        read_reg(REG_IN_COUNT, '1, 32'(n_in));
        read_reg(REG_S1_COUNT, '1, 32'(n_s1));
        read_reg(REG_S2_COUNT, '1, 32'(n_s2));
        read_reg(REG_STATUS, 32'h070A_0000, 32'h0000_0000);
        read_reg(32'h0000_0008, '1, 32'h0000_0000);
        finish_test("register reads");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
logic/demux_pkg.sv
logic/segment_sequencer.sv
logic/beat_buffer.sv
logic/transfer_counters.sv
logic/status_regs.sv
logic/stream_demux.sv
verification/stream_demux_tb.sv
